// File: src/vset_pkg.sv
//##################################################
// Shared sizes, vtype field positions and the AVL
// mode type of the vector configuration unit.
// Every stage imports it; compile it first.
//##################################################
`default_nettype none

package vset_pkg;

    // vector register file geometry
    localparam int VLEN       = 512;            // bits per vector register
    localparam int VLEN_BYTES = VLEN / 8;       // VLMAX at SEW 8, LMUL 1
    localparam int VL_W       = 7;              // holds 0..VLEN_BYTES

    // speculative configuration queue
    localparam int VSET_QUEUE_DEPTH = 8;
    localparam int VSET_IDX_W       = $clog2(VSET_QUEUE_DEPTH);
    localparam int PIPE_SLOTS       = 2;        // decode + vl select can hold a request

    // request payload widths
    localparam int VTYPE_W = 11;
    localparam int AVL_W   = 64;

    // vtype field positions
    localparam int VTYPE_VLMUL_LSB = 0;         // bits 2:0
    localparam int VTYPE_VSEW_LSB  = 3;         // bits 5:3
    localparam int VTYPE_VTA_BIT   = 6;
    localparam int VTYPE_VMA_BIT   = 7;
    localparam int VTYPE_RSVD_LSB  = 8;         // bits 10:8, must be zero

    // how the new vl is sourced
    typedef enum logic [1:0] {
        AVL_VALUE = 2'd0,                       // take the avl operand
        AVL_KEEP  = 2'd1,                       // rs1 = rd = x0, keep current vl
        AVL_MAX   = 2'd2                        // rs1 = x0, rd != x0, vl = VLMAX
    } avl_mode_e;

endpackage

`default_nettype wire

// File: src/vtype_decode.sv
//##################################################
// Stage 1 of the vset pipeline. Takes a request on
// the valid/ready handshake, checks vtype legality
// and computes VLMAX from SEW and fractional LMUL.
//##################################################
`timescale 1ns/1ps
`default_nettype none

module vtype_decode (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           req_valid_i,
    input  logic                           req_ready_i,   // from queue back-pressure
    input  logic [vset_pkg::VTYPE_W-1:0]   vtype_i,
    input  logic [vset_pkg::AVL_W-1:0]     avl_i,
    input  vset_pkg::avl_mode_e            avl_mode_i,
    input  logic                           flush_i,       // any recovery
    output logic                           s1_valid_o,
    output logic                           s1_vill_o,
    output logic [2:0]                     s1_vsew_o,
    output logic [2:0]                     s1_vlmul_o,
    output logic                           s1_vta_o,
    output logic                           s1_vma_o,
    output logic [vset_pkg::VL_W-1:0]      s1_vlmax_o,
    output logic [vset_pkg::AVL_W-1:0]     s1_avl_o,
    output vset_pkg::avl_mode_e            s1_mode_o
);
    import vset_pkg::*;

    logic [2:0]      vsew;
    logic [2:0]      vlmul;
    logic            vill;
    logic            take;
    logic [VL_W-1:0] vlmax_lmul1;
    logic [VL_W-1:0] vlmax;

    assign take  = req_valid_i && req_ready_i;
    assign vsew  = vtype_i[VTYPE_VSEW_LSB +: 3];
    assign vlmul = vtype_i[VTYPE_VLMUL_LSB +: 3];

    // only LMUL 1 or fractional, SEW up to 64
    assign vill = (vtype_i[VTYPE_W-1:VTYPE_RSVD_LSB] != '0)   // reserved bits
               || vsew[2]                                     // SEW above 64
               || ((vlmul != 3'b000) && !vlmul[2])            // LMUL 2, 4, 8
               || (vlmul == 3'b100)                           // reserved encoding
               || (vlmul[2] && (vlmul[1:0] <= vsew[1:0]));    // fraction too small

    assign vlmax_lmul1 = VL_W'(VLEN_BYTES) >> vsew;

    always_comb begin
        case (vlmul)
            3'b101:  vlmax = vlmax_lmul1 >> 3;   // mf8
            3'b110:  vlmax = vlmax_lmul1 >> 2;   // mf4
            3'b111:  vlmax = vlmax_lmul1 >> 1;   // mf2
            default: vlmax = vlmax_lmul1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            s1_valid_o <= 1'b0;                  // recovery drops the request
        end else begin
            s1_valid_o <= take;
        end
    end

    // payload loads only on a handshake
    always_ff @(posedge clk_i) begin
        if (take) begin
            s1_vill_o  <= vill;
            s1_vsew_o  <= vill ? 3'b000 : vsew;
            s1_vlmul_o <= vill ? 3'b000 : vlmul;
            s1_vta_o   <= vill ? 1'b0 : vtype_i[VTYPE_VTA_BIT];
            s1_vma_o   <= vill ? 1'b0 : vtype_i[VTYPE_VMA_BIT];
            s1_vlmax_o <= vill ? '0 : vlmax;
            s1_avl_o   <= avl_i;
            s1_mode_o  <= avl_mode_i;
        end
    end

endmodule

`default_nettype wire

// File: src/vl_select.sv
//##################################################
// Stage 2 of the vset pipeline. Picks the new vl
// from AVL mode and VLMAX, sets the narrow/wide
// enable, and tracks the youngest vl for keep mode.
//##################################################
`timescale 1ns/1ps
`default_nettype none

module vl_select (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           s1_valid_i,
    input  logic                           s1_vill_i,
    input  logic [2:0]                     s1_vsew_i,
    input  logic [2:0]                     s1_vlmul_i,
    input  logic                           s1_vta_i,
    input  logic                           s1_vma_i,
    input  logic [vset_pkg::VL_W-1:0]      s1_vlmax_i,
    input  logic [vset_pkg::AVL_W-1:0]     s1_avl_i,
    input  vset_pkg::avl_mode_e            s1_mode_i,
    input  logic                           flush_i,
    input  logic [vset_pkg::VL_W-1:0]      restore_vl_i,  // vl left after recovery
    output logic                           s2_valid_o,
    output logic                           s2_vill_o,
    output logic [2:0]                     s2_vsew_o,
    output logic [2:0]                     s2_vlmul_o,
    output logic                           s2_vta_o,
    output logic                           s2_vma_o,
    output logic [vset_pkg::VL_W-1:0]      s2_vlmax_o,
    output logic [vset_pkg::VL_W-1:0]      s2_vl_o,
    output logic                           s2_narrow_wide_o
);
    import vset_pkg::*;

    logic [VL_W-1:0]  youngest_vl_q;            // vl of the newest request seen
    logic [VL_W-1:0]  vl_d;
    logic [AVL_W-1:0] vlmax_ext;
    logic [AVL_W-1:0] avl_half;
    logic             narrow_wide_d;

    assign vlmax_ext = AVL_W'(s1_vlmax_i);
    assign avl_half  = (s1_avl_i >> 1) + AVL_W'(s1_avl_i[0]);   // ceil(avl / 2)

    always_comb begin
        if (s1_vill_i) begin
            vl_d = '0;
        end else if (s1_mode_i == AVL_KEEP) begin
            vl_d = youngest_vl_q;
        end else if (s1_mode_i == AVL_MAX) begin
            vl_d = s1_vlmax_i;
        end else if (s1_avl_i <= vlmax_ext) begin
            vl_d = s1_avl_i[VL_W-1:0];
        end else if (s1_avl_i <= (vlmax_ext << 1)) begin
            vl_d = avl_half[VL_W-1:0];           // at most VLMAX, fits
        end else begin
            vl_d = s1_vlmax_i;
        end
    end

    assign narrow_wide_d = s1_vlmul_i[2] || (vl_d <= (s1_vlmax_i >> 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            youngest_vl_q <= '0;                 // committed config after reset has vl 0
        end else if (flush_i) begin
            youngest_vl_q <= restore_vl_i;
        end else if (s1_valid_i) begin
            youngest_vl_q <= vl_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            s2_valid_o <= 1'b0;
        end else begin
            s2_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_i) begin
            s2_vill_o        <= s1_vill_i;
            s2_vsew_o        <= s1_vsew_i;
            s2_vlmul_o       <= s1_vlmul_i;
            s2_vta_o         <= s1_vta_i;
            s2_vma_o         <= s1_vma_i;
            s2_vlmax_o       <= s1_vlmax_i;
            s2_vl_o          <= vl_d;
            s2_narrow_wide_o <= narrow_wide_d;
        end
    end

endmodule

`default_nettype wire

// File: src/vset_queue.sv
//##################################################
// Stage 3. Circular queue of speculative vector
// configurations. Commit retires the oldest entry;
// recoveries rewind the tail and flush stages 1-2.
// Drives request back-pressure for the pipeline.
//##################################################
`timescale 1ns/1ps
`default_nettype none

module vset_queue (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             s2_valid_i,
    input  logic                             s2_vill_i,
    input  logic [2:0]                       s2_vsew_i,
    input  logic [2:0]                       s2_vlmul_i,
    input  logic                             s2_vta_i,
    input  logic                             s2_vma_i,
    input  logic [vset_pkg::VL_W-1:0]        s2_vlmax_i,
    input  logic [vset_pkg::VL_W-1:0]        s2_vl_i,
    input  logic                             s2_narrow_wide_i,
    input  logic                             s1_valid_i,    // in-flight count only
    input  logic                             commit_i,
    input  logic                             recover_commit_i,
    input  logic                             recover_mispredict_i,
    input  logic [vset_pkg::VSET_IDX_W-1:0]  mispredict_index_i,
    output logic                             req_ready_o,
    output logic                             flush_o,
    output logic [vset_pkg::VL_W-1:0]        restore_vl_o,
    output logic [vset_pkg::VL_W-1:0]        vl_o,
    output logic [vset_pkg::VL_W-1:0]        vlmax_o,
    output logic [2:0]                       vsew_o,
    output logic [2:0]                       vlmul_o,
    output logic                             vta_o,
    output logic                             vma_o,
    output logic                             vill_o,
    output logic                             narrow_wide_o,
    output logic [vset_pkg::VSET_IDX_W-1:0]  cfg_index_o,
    output logic                             full_o
);
    import vset_pkg::*;

    localparam int CNT_W = VSET_IDX_W + 1;
    localparam int OCC_W = $clog2(VSET_QUEUE_DEPTH + PIPE_SLOTS + 1);
    // entry = {vill, vsew, vlmul, vta, vma, vlmax, vl, narrow_wide}
    localparam int ENT_W = 10 + 2 * VL_W;

    logic [ENT_W-1:0]      mem_q [VSET_QUEUE_DEPTH];
    logic [ENT_W-1:0]      committed_q;          // last retired configuration
    logic [ENT_W-1:0]      wr_entry;
    logic [ENT_W-1:0]      cur_entry;
    logic [ENT_W-1:0]      rest_entry;
    logic [VSET_IDX_W-1:0] head_q, head_d;
    logic [VSET_IDX_W-1:0] tail_q, tail_d;
    logic [VSET_IDX_W-1:0] last_idx;
    logic [VSET_IDX_W-1:0] keep_span;
    logic [CNT_W-1:0]      count_q, count_d;
    logic [OCC_W-1:0]      occupancy;
    logic                  commit_eff;
    logic                  wr_en;

    assign flush_o    = recover_commit_i || recover_mispredict_i;
    assign commit_eff = commit_i && (count_q != '0);   // stray commit ignored
    assign wr_en      = s2_valid_i && !flush_o;        // recovery wins over a write
    assign last_idx   = tail_q - VSET_IDX_W'(1);
    assign keep_span  = mispredict_index_i - head_q;

    assign wr_entry = {s2_vill_i, s2_vsew_i, s2_vlmul_i, s2_vta_i, s2_vma_i,
                       s2_vlmax_i, s2_vl_i, s2_narrow_wide_i};

    // queued entries plus requests still in stages 1 and 2
    assign occupancy   = OCC_W'(count_q) + OCC_W'(s1_valid_i) + OCC_W'(s2_valid_i);
    assign req_ready_o = occupancy < OCC_W'(VSET_QUEUE_DEPTH);
    assign full_o      = count_q == CNT_W'(VSET_QUEUE_DEPTH);

    always_comb begin
        head_d  = commit_eff ? head_q + VSET_IDX_W'(1) : head_q;
        tail_d  = tail_q;
        count_d = count_q - CNT_W'(commit_eff);
        if (recover_commit_i) begin
            tail_d  = head_d;                    // nothing speculative survives
            count_d = '0;
        end else if (recover_mispredict_i) begin
            tail_d  = mispredict_index_i + VSET_IDX_W'(1);
            count_d = CNT_W'(keep_span) + CNT_W'(1) - CNT_W'(commit_eff);
        end else if (s2_valid_i) begin
            tail_d  = tail_q + VSET_IDX_W'(1);
            count_d = count_d + CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            count_q     <= '0;
            committed_q <= {1'b1, {(ENT_W-1){1'b0}}};   // vill, vl 0
        end else begin
            head_q  <= head_d;
            tail_q  <= tail_d;
            count_q <= count_d;
            if (commit_eff) begin
                committed_q <= mem_q[head_q];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[tail_q] <= wr_entry;
        end
    end

    // config the pipeline resumes from after a recovery
    always_comb begin
        if (recover_commit_i) begin
            rest_entry = commit_eff ? mem_q[head_q] : committed_q;
        end else begin
            rest_entry = mem_q[mispredict_index_i];
        end
    end
    assign restore_vl_o = rest_entry[VL_W:1];    // vl field

    // youngest entry, committed config when empty
    assign cur_entry   = (count_q == '0) ? committed_q : mem_q[last_idx];
    assign cfg_index_o = last_idx;
    assign {vill_o, vsew_o, vlmul_o, vta_o, vma_o, vlmax_o, vl_o, narrow_wide_o} = cur_entry;

endmodule

`default_nettype wire

// File: src/vset_unit.sv
//##################################################
// Vector configuration unit top. Chains vtype
// decode, vl selection and the speculative queue;
// a request's config shows up 3 edges after accept.
//##################################################
`timescale 1ns/1ps
`default_nettype none

module vset_unit (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             req_valid_i,
    input  logic [vset_pkg::VTYPE_W-1:0]     vtype_i,
    input  logic [vset_pkg::AVL_W-1:0]       avl_i,
    input  vset_pkg::avl_mode_e              avl_mode_i,
    input  logic                             commit_i,
    input  logic                             recover_commit_i,
    input  logic                             recover_mispredict_i,
    input  logic [vset_pkg::VSET_IDX_W-1:0]  mispredict_index_i,
    output logic                             req_ready_o,
    output logic [vset_pkg::VL_W-1:0]        vl_o,
    output logic [vset_pkg::VL_W-1:0]        vlmax_o,
    output logic [2:0]                       vsew_o,
    output logic [2:0]                       vlmul_o,
    output logic                             vta_o,
    output logic                             vma_o,
    output logic                             vill_o,
    output logic                             narrow_wide_o,
    output logic [vset_pkg::VSET_IDX_W-1:0]  cfg_index_o,
    output logic                             full_o
);
    import vset_pkg::*;

    logic             s1_valid, s1_vill, s1_vta, s1_vma;
    logic [2:0]       s1_vsew, s1_vlmul;
    logic [VL_W-1:0]  s1_vlmax;
    logic [AVL_W-1:0] s1_avl;
    avl_mode_e        s1_mode;
    logic             s2_valid, s2_vill, s2_vta, s2_vma, s2_narrow_wide;
    logic [2:0]       s2_vsew, s2_vlmul;
    logic [VL_W-1:0]  s2_vlmax, s2_vl;
    logic             flush;                     // recovery strobe from the queue
    logic [VL_W-1:0]  restore_vl;

    vtype_decode u_decode (
        .clk_i(clk_i), .reset_i(reset_i),
        .req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
        .vtype_i(vtype_i), .avl_i(avl_i), .avl_mode_i(avl_mode_i), .flush_i(flush),
        .s1_valid_o(s1_valid), .s1_vill_o(s1_vill), .s1_vsew_o(s1_vsew),
        .s1_vlmul_o(s1_vlmul), .s1_vta_o(s1_vta), .s1_vma_o(s1_vma),
        .s1_vlmax_o(s1_vlmax), .s1_avl_o(s1_avl), .s1_mode_o(s1_mode)
    );

    vl_select u_select (
        .clk_i(clk_i), .reset_i(reset_i),
        .s1_valid_i(s1_valid), .s1_vill_i(s1_vill), .s1_vsew_i(s1_vsew),
        .s1_vlmul_i(s1_vlmul), .s1_vta_i(s1_vta), .s1_vma_i(s1_vma),
        .s1_vlmax_i(s1_vlmax), .s1_avl_i(s1_avl), .s1_mode_i(s1_mode),
        .flush_i(flush), .restore_vl_i(restore_vl),
        .s2_valid_o(s2_valid), .s2_vill_o(s2_vill), .s2_vsew_o(s2_vsew),
        .s2_vlmul_o(s2_vlmul), .s2_vta_o(s2_vta), .s2_vma_o(s2_vma),
        .s2_vlmax_o(s2_vlmax), .s2_vl_o(s2_vl), .s2_narrow_wide_o(s2_narrow_wide)
    );

    vset_queue u_queue (
        .clk_i(clk_i), .reset_i(reset_i),
        .s2_valid_i(s2_valid), .s2_vill_i(s2_vill), .s2_vsew_i(s2_vsew),
        .s2_vlmul_i(s2_vlmul), .s2_vta_i(s2_vta), .s2_vma_i(s2_vma),
        .s2_vlmax_i(s2_vlmax), .s2_vl_i(s2_vl), .s2_narrow_wide_i(s2_narrow_wide),
        .s1_valid_i(s1_valid), .commit_i(commit_i),
        .recover_commit_i(recover_commit_i), .recover_mispredict_i(recover_mispredict_i),
        .mispredict_index_i(mispredict_index_i),
        .req_ready_o(req_ready_o), .flush_o(flush), .restore_vl_o(restore_vl),
        .vl_o(vl_o), .vlmax_o(vlmax_o), .vsew_o(vsew_o), .vlmul_o(vlmul_o),
        .vta_o(vta_o), .vma_o(vma_o), .vill_o(vill_o), .narrow_wide_o(narrow_wide_o),
        .cfg_index_o(cfg_index_o), .full_o(full_o)
    );

endmodule

`default_nettype wire

// File: bench/vset_cases.svh
//##################################################
// Directed cases for the vset unit testbench.
// Included inside the testbench module. The case
// loop applies the rows in order and checks them.
//##################################################
`ifndef VSET_CASES_SVH
`define VSET_CASES_SVH

// columns are op, index, vtype, avl, avl mode, exp vl, exp vlmax, exp vill, exp narrow/wide
// a recovery row carries the vtype of the config it restores
task automatic load_cases();
    // SEW sweep at LMUL 1 into queue slots 0..3
    add_case(OP_SET,        0, 11'h000,  10, AVL_VALUE, 10, 64, 0, 1);  // avl fits
    add_case(OP_SET,        0, 11'h008,  40, AVL_VALUE, 20, 32, 0, 0);  // ceil(avl/2)
    add_case(OP_SET,        0, 11'h010,  33, AVL_VALUE, 16, 16, 0, 0);  // above 2x vlmax
    add_case(OP_SET,        0, 11'h018,  15, AVL_VALUE,  8,  8, 0, 0);  // ceil(15/2)
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    // fractional lmul is always narrow/wide
    add_case(OP_SET,        0, 11'h007,   7, AVL_VALUE,  7, 32, 0, 1);  // mf2, e8
    add_case(OP_SET,        0, 11'h00e,   9, AVL_VALUE,  5,  8, 0, 1);  // mf4, e16
    add_case(OP_SET,        0, 11'h005, 100, AVL_VALUE,  8,  8, 0, 1);  // mf8, e8
    add_case(OP_SET,        0, 11'h017,   8, AVL_VALUE,  8,  8, 0, 1);  // mf2, e32
    add_case(OP_SET,        0, 11'h0c8,  16, AVL_VALUE, 16, 32, 0, 1);  // vta, vma, half vlmax
    // drain to an empty queue
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    // illegal vtypes in slots 1..5
    add_case(OP_SET,        0, 11'h100,   5, AVL_VALUE,  0,  0, 1, 1);  // reserved bit
    add_case(OP_SET,        0, 11'h020,   5, AVL_VALUE,  0,  0, 1, 1);  // sew 128
    add_case(OP_SET,        0, 11'h001,   5, AVL_VALUE,  0,  0, 1, 1);  // lmul 2
    add_case(OP_SET,        0, 11'h00d,   5, AVL_VALUE,  0,  0, 1, 1);  // mf8 with e16
    add_case(OP_SET,        0, 11'h01f,   5, AVL_VALUE,  0,  0, 1, 1);  // mf2 with e64
    // keep and max modes until the queue fills up
    add_case(OP_SET,        0, 11'h000,   0, AVL_KEEP,   0, 64, 0, 1);  // keeps vl 0 from vill
    add_case(OP_SET,        0, 11'h008,   0, AVL_MAX,   32, 32, 0, 0);
    add_case(OP_SET,        0, 11'h000,   0, AVL_KEEP,  32, 64, 0, 1);  // eighth entry
    add_case(OP_SET_FULL,   0, 11'h018,   3, AVL_VALUE,  3,  8, 0, 1);  // held until commit
    // mispredict back to slot 7, then keep picks up the restored vl
    add_case(OP_MISPREDICT, 7, 11'h008,   0, AVL_VALUE, 32, 32, 0, 0);
    add_case(OP_SET,        0, 11'h000,   0, AVL_KEEP,  32, 64, 0, 1);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);  // slot 7 committed
    // exception recovery to the committed config
    add_case(OP_RECOVER,    0, 11'h008,   0, AVL_VALUE, 32, 32, 0, 0);
    add_case(OP_SET,        0, 11'h000,   0, AVL_KEEP,  32, 64, 0, 1);
    add_case(OP_COMMIT,     0, 11'h000,   0, AVL_VALUE,  0,  0, 0, 0);
endtask

`endif

// File: bench/vset_unit_tb.sv
//##################################################
// Testbench for the vset unit. Applies the directed
// case table, then LFSR-drawn requests checked
// against a model of the vtype and vl rules.
//##################################################
`timescale 1ns/1ps
`default_nettype none

module vset_unit_tb;
    import vset_pkg::*;

    localparam int MAX_CASES  = 64;
    localparam int NUM_RANDOM = 40;

    typedef enum logic [2:0] {
        OP_SET, OP_SET_FULL, OP_COMMIT, OP_RECOVER, OP_MISPREDICT
    } case_op_e;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  req_valid = 1'b0;
    logic [VTYPE_W-1:0]    vtype = '0;
    logic [AVL_W-1:0]      avl = '0;
    avl_mode_e             avl_mode = AVL_VALUE;
    logic                  commit = 1'b0;
    logic                  recover_commit = 1'b0;
    logic                  recover_mispredict = 1'b0;
    logic [VSET_IDX_W-1:0] mispredict_index = '0;
    logic                  req_ready, vta, vma, vill, narrow_wide, full;
    logic [VL_W-1:0]       vl, vlmax;
    logic [2:0]            vsew, vlmul;
    logic [VSET_IDX_W-1:0] cfg_index;

    case_op_e              case_op    [MAX_CASES];
    logic [VSET_IDX_W-1:0] case_idx   [MAX_CASES];   // mispredict index
    logic [VTYPE_W-1:0]    case_vtype [MAX_CASES];
    logic [AVL_W-1:0]      case_avl   [MAX_CASES];
    avl_mode_e             case_mode  [MAX_CASES];
    int                    case_vl    [MAX_CASES];
    int                    case_vlmax [MAX_CASES];
    logic                  case_vill  [MAX_CASES];
    logic                  case_nw    [MAX_CASES];
    int                    num_cases = 0;
    int                    cycle_count = 0;
    int                    model_vl = 0;               // youngest vl, model side
    logic [31:0]           lfsr = 32'h80632baf;

    vset_unit DUT (
        .clk_i(clk), .reset_i(reset), .req_valid_i(req_valid), .vtype_i(vtype),
        .avl_i(avl), .avl_mode_i(avl_mode), .commit_i(commit),
        .recover_commit_i(recover_commit), .recover_mispredict_i(recover_mispredict),
        .mispredict_index_i(mispredict_index), .req_ready_o(req_ready),
        .vl_o(vl), .vlmax_o(vlmax), .vsew_o(vsew), .vlmul_o(vlmul), .vta_o(vta),
        .vma_o(vma), .vill_o(vill), .narrow_wide_o(narrow_wide),
        .cfg_index_o(cfg_index), .full_o(full)
    );

    always #2 clk = ~clk;                              // 4 ns period

    task automatic add_case(input case_op_e op, input int idx, input logic [VTYPE_W-1:0] vt,
                            input logic [AVL_W-1:0] a, input avl_mode_e m, input int exp_vl,
                            input int exp_vlmax, input logic exp_vill, input logic exp_nw);
        case_op[num_cases]    = op;
        case_idx[num_cases]   = VSET_IDX_W'(idx);
        case_vtype[num_cases] = vt;
        case_avl[num_cases]   = a;
        case_mode[num_cases]  = m;
        case_vl[num_cases]    = exp_vl;
        case_vlmax[num_cases] = exp_vlmax;
        case_vill[num_cases]  = exp_vill;
        case_nw[num_cases]    = exp_nw;
        num_cases             = num_cases + 1;
    endtask

    `include "vset_cases.svh"

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input longint got, input longint want);
        assert (got == want) else begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            abort_run();
        end
    endtask

    task automatic check_config(input logic [VTYPE_W-1:0] vt, input int exp_vl,
                                input int exp_vlmax, input logic exp_vill, input logic exp_nw);
        logic [2:0] exp_sew;
        logic [2:0] exp_lmul;
        logic [1:0] exp_mask;
        exp_sew  = exp_vill ? 3'b000 : vt[5:3];       // illegal vtype clears the fields
        exp_lmul = exp_vill ? 3'b000 : vt[2:0];
        exp_mask = exp_vill ? 2'b00 : vt[7:6];        // {vma, vta}
        check_value("vl_o", vl, exp_vl);
        check_value("vlmax_o", vlmax, exp_vlmax);
        check_value("vill_o", vill, exp_vill);
        check_value("narrow_wide_o", narrow_wide, exp_nw);
        check_value("vsew_o", vsew, exp_sew);
        check_value("vlmul_o", vlmul, exp_lmul);
        check_value("vta_o", vta, exp_mask[0]);
        check_value("vma_o", vma, exp_mask[1]);
    endtask

    task automatic start_request(input logic [VTYPE_W-1:0] vt, input logic [AVL_W-1:0] a,
                                 input avl_mode_e m);
        @(negedge clk);
        req_valid = 1'b1;
        vtype     = vt;
        avl       = a;
        avl_mode  = m;
    endtask

    // hold the request until ready, then ride out the 3-edge latency
    task automatic finish_request();
        while (!req_ready) @(negedge clk);
        @(posedge clk);                                // handshake edge
        @(negedge clk);
        req_valid = 1'b0;
        repeat (2) @(posedge clk);                     // stage 2, then queue write
        @(negedge clk);
    endtask

    task automatic pulse_commit();
        @(negedge clk);
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
    endtask

    task automatic pulse_recover(input logic mispredict, input logic [VSET_IDX_W-1:0] idx);
        @(negedge clk);
        recover_commit     = !mispredict;
        recover_mispredict = mispredict;
        mispredict_index   = idx;
        @(negedge clk);
        recover_commit     = 1'b0;
        recover_mispredict = 1'b0;
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic draw_request(output logic [VTYPE_W-1:0] vt, output logic [AVL_W-1:0] a,
                                output avl_mode_e m);
        logic [2:0]  lmul;
        logic [2:0]  sew;
        logic [2:0]  rsvd;
        logic [1:0]  mask_bits;
        logic [1:0]  pick;
        logic [31:0] hi;
        lmul      = 3'(draw_bits(3));                  // about half illegal
        sew       = 3'(draw_bits(2));
        sew[2]    = (draw_bits(3) == 0);               // sew 128 and up now and then
        mask_bits = 2'(draw_bits(2));
        rsvd      = 3'(draw_bits(3));
        if (draw_bits(3) != 0) rsvd = 3'b000;          // reserved bits rarely set
        vt = {rsvd, mask_bits, sew, lmul};
        if (draw_bits(4) == 0) begin
            hi = draw_bits(32);
            a  = {hi, draw_bits(32)};                  // huge avl
        end else begin
            a = AVL_W'(draw_bits(8));                  // up to 4x the largest vlmax
        end
        pick = 2'(draw_bits(2));
        case (pick)
            2'd2:    m = AVL_KEEP;
            2'd3:    m = AVL_MAX;
            default: m = AVL_VALUE;
        endcase
    endtask

    task automatic predict_config(input logic [VTYPE_W-1:0] vt, input logic [AVL_W-1:0] a,
                                  input avl_mode_e m, output int exp_vl, output int exp_vlmax,
                                  output logic exp_vill, output logic exp_nw);
        int   sew;
        int   lmul;
        logic frac;
        sew      = vt[5:3];
        lmul     = vt[2:0];
        frac     = (lmul >= 5);                        // mf8, mf4, mf2
        exp_vill = (vt[10:8] != 0) || (sew > 3) || (lmul >= 1 && lmul <= 4)
                || (frac && (lmul - 4) <= sew);
        if (exp_vill) begin
            exp_vlmax = 0;                             // fields cleared
            exp_vl    = 0;
            frac      = 1'b0;
        end else begin
            exp_vlmax = VLEN_BYTES >> sew;
            if (frac) exp_vlmax = exp_vlmax >> (8 - lmul);
            if (m == AVL_KEEP) exp_vl = model_vl;
            else if (m == AVL_MAX) exp_vl = exp_vlmax;
            else if (a <= AVL_W'(exp_vlmax)) exp_vl = int'(a);
            else if (a <= AVL_W'(2 * exp_vlmax)) exp_vl = int'((a + 64'd1) >> 1);
            else exp_vl = exp_vlmax;
        end
        exp_nw   = frac || (exp_vl <= exp_vlmax / 2);
        model_vl = exp_vl;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > 10 * (num_cases + NUM_RANDOM)) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial begin : main
        logic [VTYPE_W-1:0] rnd_vtype;
        logic [AVL_W-1:0]   rnd_avl;
        avl_mode_e          rnd_mode;
        int                 exp_vl;
        int                 exp_vlmax;
        logic               exp_vill;
        logic               exp_nw;
        load_cases();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_value("req_ready_o after reset", req_ready, 1);
        check_value("full_o after reset", full, 0);
        check_value("vill_o after reset", vill, 1);
        check_value("vl_o after reset", vl, 0);
        for (int i = 0; i < num_cases; i++) begin
            case (case_op[i])
                OP_SET, OP_SET_FULL: begin
                    start_request(case_vtype[i], case_avl[i], case_mode[i]);
                    if (case_op[i] == OP_SET_FULL) begin
                        check_value("req_ready_o with full queue", req_ready, 0);
                        check_value("full_o", full, 1);
                        pulse_commit();                // frees one slot, request held
                    end
                    finish_request();
                end
                OP_COMMIT:     pulse_commit();
                OP_RECOVER:    pulse_recover(1'b0, '0);
                OP_MISPREDICT: begin
                    pulse_recover(1'b1, case_idx[i]);
                    check_value("cfg_index_o", cfg_index, case_idx[i]);
                end
                default: ;
            endcase
            if (case_op[i] != OP_COMMIT) begin
                check_config(case_vtype[i], case_vl[i], case_vlmax[i], case_vill[i],
                             case_nw[i]);
                model_vl = case_vl[i];                 // restored or newest vl
            end
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            draw_request(rnd_vtype, rnd_avl, rnd_mode);
            predict_config(rnd_vtype, rnd_avl, rnd_mode, exp_vl, exp_vlmax, exp_vill, exp_nw);
            start_request(rnd_vtype, rnd_avl, rnd_mode);
            finish_request();
            check_config(rnd_vtype, exp_vl, exp_vlmax, exp_vill, exp_nw);
            pulse_commit();                            // queue never fills here
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
src/vset_pkg.sv
src/vtype_decode.sv
src/vl_select.sv
src/vset_queue.sv
src/vset_unit.sv
bench/vset_unit_tb.sv
